//--- reg_bank.sv
`timescale 1ns/10ps

module reg_bank import spi_bridge_pkg::*; #(
   parameter int ACK_DELAY = 2   // extra wait states, 0 to 3
) (
   input  logic  clk_i,
   input  logic  rst_i,
   input  logic  cyc_i,
   input  logic  stb_i,
   input  logic  we_i,
   input  adr_t  adr_i,
   input  byte_t wdat_i,
   output logic  ack_o,
   output byte_t rdat_o
);

   byte_t      mem [0:127];
   logic [1:0] dly;      // wait states seen in this cycle
   logic       ack_go;   // ack rises on the next edge

   // stb rising gives ack ACK_DELAY+1 clocks later
   assign ack_go = cyc_i && stb_i && !ack_o && (dly == 2'(ACK_DELAY));

   // ------------------------------------------------------------------------
   // acknowledge
   // ------------------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ack_o <= 1'b0;
         dly   <= 2'd0;
      end else begin
         ack_o <= ack_go;                        // single pulse
         if (cyc_i && stb_i && !ack_o && !ack_go) begin
            dly <= dly + 2'd1;
         end else begin
            dly <= 2'd0;                         // idle or cycle finished
         end
      end
   end

   // ------------------------------------------------------------------------
   // storage, access lands on the edge that raises ack
   // ------------------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         for (int i = 0; i < 128; i++) begin
            mem[i] <= '0;
         end
      end else if (ack_go && we_i) begin
         mem[adr_i] <= wdat_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (ack_go) begin
         rdat_o <= mem[adr_i];                   // valid while ack is high
      end
   end

   a_ack_with_stb: assert property (@(posedge clk_i) disable iff (rst_i)
      ack_o |-> stb_i);

endmodule

//--- run_sim.sh
#!/bin/sh
# build the testbench with verilator, run it, decide on the log contents

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module tb_spi_bridge \
   -f spi_bridge_top.f -o tb_spi_bridge_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/tb_spi_bridge_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^Result: PASSED$" "$LOG"; then
   exit 0
fi
exit 1

//--- spi_bit_counter.sv
`timescale 1ns/10ps

module spi_bit_counter (
   input  logic clk_i,
   input  logic rst_i,
   input  logic sck_rise_i,
   input  logic sck_fall_i,
   input  logic ssel_act_i,
   output logic word_done_o,     // rx word complete, one clock after the rise
   output logic word_load_o,     // next tx word is taken on this fall
   output logic first_word_o     // command byte still in flight
);

   logic [2:0] bit_cnt;          // bits sampled so far in this word
   logic       load_pend;        // word done, waiting for the next fall

   // ------------------------------------------------------------------------
   // bit counter, held clear outside a frame
   // ------------------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i || !ssel_act_i) begin
         bit_cnt      <= 3'd0;
         load_pend    <= 1'b0;
         word_done_o  <= 1'b0;
         first_word_o <= 1'b1;
      end else begin
         // registered so rx_word is already complete when this is seen
         word_done_o <= sck_rise_i && (bit_cnt == 3'd7);
         if (sck_rise_i) begin
            bit_cnt <= bit_cnt + 3'd1;   // wraps to 0 after bit 0
         end
         if (word_done_o) begin
            load_pend    <= 1'b1;
            first_word_o <= 1'b0;        // still high during the first pulse
         end else if (sck_fall_i) begin
            load_pend <= 1'b0;
         end
      end
   end

   // must hit the same fall as the shift register, so not registered
   assign word_load_o = load_pend & sck_fall_i;

   a_done_in_frame: assert property (@(posedge clk_i) disable iff (rst_i)
      word_done_o |-> ssel_act_i);

endmodule

//--- spi_bridge_pkg.sv
package spi_bridge_pkg;

   // ------------------------------------------------------------------------
   // data widths
   // ------------------------------------------------------------------------
   typedef logic [7:0] byte_t;   // one spi word, also one bus data value
   typedef logic [6:0] adr_t;    // bus address from the command byte

   // command byte layout: {we, adr[6:0]}
   localparam int CMD_WE_BIT = 7;

   // ------------------------------------------------------------------------
   // bridge fsm
   // ------------------------------------------------------------------------
   typedef enum logic [2:0] {
      ST_IDLE,   // ssel high, nothing going on
      ST_ADDR,   // waiting for the command byte
      ST_BUSY,   // frame open, no bus cycle running
      ST_PUSH,   // bus write cycle open
      ST_PULL    // bus read cycle open
   } bridge_state_t;

endpackage

//--- spi_bridge_top.f
spi_bridge_pkg.sv
spi_pin_sync.sv
spi_bit_counter.sv
spi_shift_reg.sv
spi_bus_fsm.sv
reg_bank.sv
spi_bridge_top.sv
tb_spi_bridge.sv

//--- spi_bridge_top.sv
`timescale 1ns/10ps

module spi_bridge_top import spi_bridge_pkg::*; #(
   parameter byte_t HEADER_BYTE = 8'hA7,
   parameter int    ACK_DELAY   = 2
) (
   input  logic  clk_i,
   input  logic  rst_i,
   input  logic  sck_i,
   input  logic  ssel_i,
   input  logic  mosi_i,
   input  byte_t status_i,     // sent back during write frames
   output logic  miso_o,
   output logic  active_o,
   output logic  underrun_o
);

   // spi side
   logic  sck_rise;
   logic  sck_fall;
   logic  ssel_act;
   logic  frame_start;
   logic  mosi_s;
   logic  word_done;
   logic  word_load;
   logic  first_word;
   byte_t rx_word;
   byte_t tx_word;

   // bus side
   logic  cyc;
   logic  stb;
   logic  we;
   adr_t  adr;
   byte_t wdat;
   logic  ack;
   byte_t rdat;

   // ------------------------------------------------------------------------
   // spi front end
   // ------------------------------------------------------------------------
   spi_pin_sync spi_pin_sync_inst (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .sck_i         (sck_i),
      .ssel_i        (ssel_i),
      .mosi_i        (mosi_i),
      .sck_rise_o    (sck_rise),
      .sck_fall_o    (sck_fall),
      .ssel_act_o    (ssel_act),
      .frame_start_o (frame_start),
      .mosi_o        (mosi_s)
   );

   spi_bit_counter spi_bit_counter_inst (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .sck_rise_i   (sck_rise),
      .sck_fall_i   (sck_fall),
      .ssel_act_i   (ssel_act),
      .word_done_o  (word_done),
      .word_load_o  (word_load),
      .first_word_o (first_word)
   );

   spi_shift_reg #(
      .HEADER_BYTE (HEADER_BYTE)
   ) spi_shift_reg_inst (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .sck_rise_i    (sck_rise),
      .sck_fall_i    (sck_fall),
      .frame_start_i (frame_start),
      .word_load_i   (word_load),
      .mosi_i        (mosi_s),
      .tx_word_i     (tx_word),
      .rx_word_o     (rx_word),
      .miso_o        (miso_o)
   );

   // ------------------------------------------------------------------------
   // bridge and bus slave
   // ------------------------------------------------------------------------
   spi_bus_fsm spi_bus_fsm_inst (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .ssel_act_i   (ssel_act),
      .word_done_i  (word_done),
      .word_load_i  (word_load),
      .first_word_i (first_word),
      .rx_word_i    (rx_word),
      .status_i     (status_i),
      .ack_i        (ack),
      .rdat_i       (rdat),
      .cyc_o        (cyc),
      .stb_o        (stb),
      .we_o         (we),
      .adr_o        (adr),
      .wdat_o       (wdat),
      .tx_word_o    (tx_word),
      .active_o     (active_o),
      .underrun_o   (underrun_o)
   );

   reg_bank #(
      .ACK_DELAY (ACK_DELAY)
   ) reg_bank_inst (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .cyc_i  (cyc),
      .stb_i  (stb),
      .we_i   (we),
      .adr_i  (adr),
      .wdat_i (wdat),
      .ack_o  (ack),
      .rdat_o (rdat)
   );

endmodule

//--- spi_bus_fsm.sv
`timescale 1ns/10ps

module spi_bus_fsm import spi_bridge_pkg::*; (
   input  logic  clk_i,
   input  logic  rst_i,
   input  logic  ssel_act_i,
   input  logic  word_done_i,
   input  logic  word_load_i,
   input  logic  first_word_i,
   input  byte_t rx_word_i,
   input  byte_t status_i,
   input  logic  ack_i,
   input  byte_t rdat_i,
   output logic  cyc_o,
   output logic  stb_o,
   output logic  we_o,
   output adr_t  adr_o,
   output byte_t wdat_o,
   output byte_t tx_word_o,
   output logic  active_o,
   output logic  underrun_o
);

   bridge_state_t state;
   logic          we_r;       // write flag of the current frame
   logic          rd_valid;   // fetched byte ready for the next word_load
   byte_t         rd_data;
   logic          cmd_done;   // command byte just arrived
   logic          push_go;    // data byte arrived in a write frame
   logic          pull_go;    // previous read byte taken, fetch again

   assign cmd_done = (state == ST_ADDR) && ssel_act_i && word_done_i && first_word_i;
   assign push_go  = (state == ST_BUSY) && ssel_act_i && we_r && word_done_i;
   assign pull_go  = (state == ST_BUSY) && ssel_act_i && !we_r && word_load_i;

   assign we_o     = we_r;
   assign active_o = (state != ST_IDLE);

   // status in write frames and the fetched byte or 00 in read frames
   assign tx_word_o = we_r ? status_i : (rd_valid ? rd_data : 8'h00);

   // ------------------------------------------------------------------------
   // control
   // ------------------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state      <= ST_IDLE;
         cyc_o      <= 1'b0;
         stb_o      <= 1'b0;
         we_r       <= 1'b0;
         rd_valid   <= 1'b0;
         underrun_o <= 1'b0;
      end else begin
         // shift register wanted a read byte that is not there yet
         underrun_o <= word_load_i && !we_r && !rd_valid;
         if (word_load_i) begin
            rd_valid <= 1'b0;                    // byte consumed
         end

         case (state)
            ST_IDLE: begin
               rd_valid <= 1'b0;
               if (ssel_act_i) begin
                  state <= ST_ADDR;
               end
            end

            ST_ADDR: begin
               if (!ssel_act_i) begin
                  state <= ST_IDLE;              // aborted inside the command
               end else if (cmd_done) begin
                  we_r <= rx_word_i[CMD_WE_BIT];
                  if (rx_word_i[CMD_WE_BIT]) begin
                     state <= ST_BUSY;           // wait for the first data byte
                  end else begin
                     state <= ST_PULL;           // prefetch right away
                     cyc_o <= 1'b1;
                     stb_o <= 1'b1;
                  end
               end
            end

            ST_BUSY: begin
               if (!ssel_act_i) begin
                  state <= ST_IDLE;
               end else if (push_go || pull_go) begin
                  state <= push_go ? ST_PUSH : ST_PULL;
                  cyc_o <= 1'b1;
                  stb_o <= 1'b1;
               end
            end

            // an open cycle always runs to its ack even after ssel rises
            ST_PUSH, ST_PULL: begin
               if (ack_i) begin
                  cyc_o <= 1'b0;
                  stb_o <= 1'b0;
                  state <= ssel_act_i ? ST_BUSY : ST_IDLE;
                  if (state == ST_PULL) begin
                     rd_valid <= 1'b1;           // wins over a same-cycle load
                  end
               end
            end

            default: state <= ST_IDLE;
         endcase
      end
   end

   // ------------------------------------------------------------------------
   // payload
   // ------------------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (cmd_done) begin
         adr_o <= adr_t'(rx_word_i[CMD_WE_BIT-1:0]);
      end
      if (push_go) begin
         wdat_o <= rx_word_i;                    // held for the whole cycle
      end
      if (state == ST_PULL && ack_i) begin
         rd_data <= rdat_i;
      end
   end

   a_stb_in_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
      stb_o |-> cyc_o);

   a_we_stable: assert property (@(posedge clk_i) disable iff (rst_i)
      cyc_o |=> !cyc_o || $stable(we_o));

endmodule

//--- spi_pin_sync.sv
`timescale 1ns/10ps

module spi_pin_sync (
   input  logic clk_i,
   input  logic rst_i,
   input  logic sck_i,           // raw pin, sampled like any other input
   input  logic ssel_i,
   input  logic mosi_i,
   output logic sck_rise_o,
   output logic sck_fall_o,
   output logic ssel_act_o,
   output logic frame_start_o,
   output logic mosi_o
);

   logic [2:0] sck_q;            // [1:0] sync stages, [2] previous value
   logic [2:0] ssel_q;
   logic [1:0] mosi_q;

   // ------------------------------------------------------------------------
   // synchronizers
   // ------------------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         sck_q  <= 3'b000;       // mode 0 idles low
         ssel_q <= 3'b111;       // deselected
         mosi_q <= 2'b00;
      end else begin
         sck_q  <= {sck_q[1:0], sck_i};
         ssel_q <= {ssel_q[1:0], ssel_i};
         mosi_q <= {mosi_q[0], mosi_i};
      end
   end

   // edge pulses, registered so a pin edge shows up 3 clocks later
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         sck_rise_o    <= 1'b0;
         sck_fall_o    <= 1'b0;
         frame_start_o <= 1'b0;
      end else begin
         sck_rise_o    <=  sck_q[1] & ~sck_q[2];
         sck_fall_o    <= ~sck_q[1] &  sck_q[2];
         frame_start_o <= ~ssel_q[1] &  ssel_q[2];   // ssel falling
      end
   end

   assign ssel_act_o = ~ssel_q[2];   // lines up with frame_start_o
   assign mosi_o     = mosi_q[1];    // stable long before the rise pulse

   a_one_edge: assert property (@(posedge clk_i) disable iff (rst_i)
      !(sck_rise_o && sck_fall_o));

endmodule

//--- spi_shift_reg.sv
`timescale 1ns/10ps

module spi_shift_reg import spi_bridge_pkg::*; #(
   parameter byte_t HEADER_BYTE = 8'hA7    // first byte out of every frame
) (
   input  logic  clk_i,
   input  logic  rst_i,
   input  logic  sck_rise_i,
   input  logic  sck_fall_i,
   input  logic  frame_start_i,
   input  logic  word_load_i,
   input  logic  mosi_i,
   input  byte_t tx_word_i,
   output byte_t rx_word_o,
   output logic  miso_o
);

   byte_t rx_sr;   // msb first, so new bits enter at the bottom
   byte_t tx_sr;

   // ------------------------------------------------------------------------
   // receive side
   // ------------------------------------------------------------------------
   // mode 0 samples on the rising edge
   always_ff @(posedge clk_i) begin
      if (sck_rise_i) begin
         rx_sr <= {rx_sr[6:0], mosi_i};
      end
   end

   assign rx_word_o = rx_sr;   // valid when word_done is seen

   // ------------------------------------------------------------------------
   // transmit side
   // ------------------------------------------------------------------------
   // msb sits on miso; the master samples it on the next rise.
   // the header goes in at frame start, well before the first rise.
   // on the fall after bit 0 the next word replaces the shift
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         tx_sr <= '0;                        // miso low out of reset
      end else if (frame_start_i) begin
         tx_sr <= HEADER_BYTE;
      end else if (word_load_i) begin
         tx_sr <= tx_word_i;
      end else if (sck_fall_i) begin
         tx_sr <= {tx_sr[6:0], 1'b0};        // next bit up
      end
   end

   assign miso_o = tx_sr[7];

endmodule

//--- tb_spi_bridge.sv
`timescale 1ns/10ps

module tb_spi_bridge import spi_bridge_pkg::*; ();

   localparam byte_t HEADER     = 8'hA7;
   localparam int    HALF_CLKS  = 8;     // 160 ns sck half period at 20 ns clk
   localparam int    WAIT_LIMIT = 200;   // clocks allowed for the bridge to go idle

   logic  clk_i;
   logic  rst_i;
   logic  sck_i;
   logic  ssel_i;
   logic  mosi_i;
   byte_t status_i;
   logic  miso_o;
   logic  active_o;
   logic  underrun_o;

   byte_t ref_mem [0:127];   // mirror of the register bank
   byte_t mosi_bytes[$];     // command first, then data
   byte_t miso_bytes[$];     // full bytes seen by the master
   byte_t got_q[$];
   byte_t exp_q[$];
   string tag_q[$];
   int    errors;
   int    checks;
   int    err_mark;          // error count when the current test began
   int    underruns;

   spi_bridge_top #(
      .HEADER_BYTE (HEADER),
      .ACK_DELAY   (2)
   ) spi_bridge_top_inst (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .sck_i      (sck_i),
      .ssel_i     (ssel_i),
      .mosi_i     (mosi_i),
      .status_i   (status_i),
      .miso_o     (miso_o),
      .active_o   (active_o),
      .underrun_o (underrun_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #10 clk_i = ~clk_i;
   end

   // ------------------------------------------------------------------------
   // reference model and checking
   // ------------------------------------------------------------------------
   // byte the master should see at position pos of a frame
   function automatic byte_t expected_miso(input int pos, input byte_t cmd, input byte_t status);
      if (pos == 0) begin
         return HEADER;
      end else if (cmd[7]) begin
         return status;                  // write frame echoes status
      end else begin
         return ref_mem[cmd[6:0]];       // read frame repeats the addressed byte
      end
   endfunction

   function automatic byte_t rand_byte();
      int r;
      r = $urandom;
      return r[7:0];
   endfunction

   task automatic check(input byte_t got, input byte_t exp, input string msg);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Mismatch at %0d ns: %s, got %02h expected %02h", $time, msg, got, exp);
      end
   endtask

   // compare whatever the frames queued up one edge later
   always @(posedge clk_i) begin
      while (got_q.size() > 0) begin
         check(got_q.pop_front(), exp_q.pop_front(), tag_q.pop_front());
      end
   end

   always @(posedge clk_i) begin
      if (!rst_i && underrun_o) begin
         underruns++;
      end
   end

   task automatic end_run();
      $display("checks %0d, errors %0d, underrun pulses %0d", checks, errors, underruns);
      if (errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   endtask

   task automatic finish_test(input string name);
      string verdict;
      if (errors == err_mark) begin
         verdict = "ok";
      end else begin
         verdict = "failed";
      end
      $display("%s: %s, %0d errors", name, verdict, errors - err_mark);
      err_mark = errors;
   endtask

   // ------------------------------------------------------------------------
   // spi master
   // ------------------------------------------------------------------------
   task automatic next_drive_point(input int n);
      repeat (n) @(posedge clk_i);
      #2;                                // inputs move 2 ns after the edge
   endtask

   // last_bits below 8 cuts the last byte short and raises ssel mid-byte
   task automatic spi_frame(input int last_bits);
      byte_t tx;
      byte_t rx;
      int    nbits;
      miso_bytes.delete();
      ssel_i = 1'b0;
      for (int w = 0; w < mosi_bytes.size(); w++) begin
         tx    = mosi_bytes[w];
         nbits = (w == mosi_bytes.size() - 1) ? last_bits : 8;
         rx    = 8'h00;
         for (int b = 7; b >= 8 - nbits; b--) begin
            mosi_i = tx[b];              // mode 0 sets data while sck is low
            next_drive_point(HALF_CLKS);
            sck_i = 1'b1;
            rx[b] = miso_o;              // master samples on the rise
            next_drive_point(HALF_CLKS);
            sck_i = 1'b0;
         end
         if (nbits == 8) begin
            miso_bytes.push_back(rx);
         end
      end
      next_drive_point(HALF_CLKS);
      ssel_i = 1'b1;
      mosi_i = 1'b0;
   endtask

   task automatic wait_idle();
      int n;
      n = 0;
      while ((active_o || got_q.size() > 0) && n < WAIT_LIMIT) begin
         next_drive_point(1);
         n++;
      end
      if (active_o || got_q.size() > 0) begin
         $display("Timeout: bridge still busy %0d clocks after the frame ended", WAIT_LIMIT);
         errors++;
         end_run();
      end else begin
         next_drive_point(4);            // deselect gap between frames
      end
   endtask

   // runs mosi_bytes as one frame, queues its checks and updates the model
   task automatic run_frame(input int last_bits, input string name);
      byte_t cmd;
      cmd      = mosi_bytes[0];
      status_i = rand_byte();
      spi_frame(last_bits);
      for (int i = 0; i < miso_bytes.size(); i++) begin
         got_q.push_back(miso_bytes[i]);
         exp_q.push_back(expected_miso(i, cmd, status_i));
         tag_q.push_back($sformatf("%s byte %0d", name, i));
      end
      if (cmd[7]) begin
         for (int i = 1; i < miso_bytes.size(); i++) begin
            ref_mem[cmd[6:0]] = mosi_bytes[i];   // last full byte wins
         end
      end
      wait_idle();
   endtask

   // ------------------------------------------------------------------------
   // tests
   // ------------------------------------------------------------------------
   initial begin
      int    r;
      adr_t  adr;
      byte_t last;
      void'($urandom(61));
      errors    = 0;
      checks    = 0;
      err_mark  = 0;
      underruns = 0;
      rst_i    = 1'b1;
      sck_i    = 1'b0;
      ssel_i   = 1'b1;
      mosi_i   = 1'b0;
      status_i = 8'h00;
      for (int i = 0; i < 128; i++) begin
         ref_mem[i] = 8'h00;
      end
      next_drive_point(8);
      rst_i = 1'b0;
      next_drive_point(1);

      check(8'(active_o), 8'h00, "active_o after reset");
      check(8'(underrun_o), 8'h00, "underrun_o after reset");
      check(8'(miso_o), 8'h00, "miso_o after reset");
      finish_test("test 1 reset state");

      for (int f = 0; f < 3; f++) begin   // command-only frames carry the header alone
         mosi_bytes = '{rand_byte()};
         run_frame(8, $sformatf("header frame %0d", f));
      end
      finish_test("test 2 header byte");

      r    = $urandom;
      adr  = r[6:0];
      mosi_bytes = '{{1'b1, adr}, rand_byte(), rand_byte(), rand_byte(), rand_byte()};
      last = mosi_bytes[4];
      run_frame(8, "burst write");
      mosi_bytes = '{{1'b0, adr}, 8'h00, 8'h00, 8'h00, 8'h00};
      run_frame(8, "burst read");
      for (int i = 1; i < 5; i++) begin
         check(miso_bytes[i], last, $sformatf("readback of last write, byte %0d", i));
      end
      finish_test("test 3 write then read");

      for (int f = 0; f < 50; f++) begin
         r   = $urandom;
         adr = r[8] ? r[6:0] : {3'b011, r[3:0]};   // half land on a small set
         mosi_bytes = '{{r[9], adr}};
         for (int i = 0; i < r[11:10] + 1; i++) begin
            mosi_bytes.push_back(rand_byte());
         end
         run_frame(8, $sformatf("random frame %0d", f));
      end
      check(8'(underruns != 0), 8'h00, "underrun pulses at 160 ns half period");
      finish_test("test 4 random frames");

      r   = $urandom;
      adr = r[6:0];
      mosi_bytes = '{{1'b1, adr}, rand_byte(), rand_byte()};
      run_frame(4, "aborted write");           // second data byte cut after 4 bits
      mosi_bytes = '{{1'b0, adr}, 8'h00};
      run_frame(8, "read after abort");
      finish_test("test 5 aborted frame");

      end_run();
   end

endmodule
